//--- common/sorted_lists_params.svh
/*
  Sizes and latencies shared by the sorted list design and its testbench.
  Latencies count cycles from the accepting clock edge to the sampled strobe.
*/
`ifndef SORTED_LISTS_PARAMS_SVH
`define SORTED_LISTS_PARAMS_SVH

// List geometry
`define SL_ENTRIES 4
`define SL_LISTS 64

// Field widths
`define SL_ID_W 6
`define SL_KEY_W 64
`define SL_SIZE_W 32
`define SL_LEVEL_W 8

// Update accept to error strobe
`define UPT_LATENCY 5
// Query accept to response, four fixed stages plus one per sorter layer
`define QRY_LATENCY (4 + `SL_ENTRIES)
// No forwarding, so updates to one ID must be spaced at least this far
`define UPT_SPACING 5

`endif

//--- common/sorted_lists_pkg.sv
/*
  Shared types for the sorted list design.
  Widths come from the params header.
*/
`default_nettype none
`include "sorted_lists_params.svh"

package sorted_lists_pkg;

  // Scalars
  typedef logic [`SL_ID_W-1:0]    id_t;
  typedef logic [`SL_KEY_W-1:0]   key_t;
  typedef logic [`SL_SIZE_W-1:0]  size_t;
  typedef logic [`SL_LEVEL_W-1:0] level_t;
  typedef logic [7:0]             listsize_t;

  // Update opcodes
  typedef enum logic [1:0] {
    OP_CLEAR   = 2'd0,
    OP_ADD     = 2'd1,
    OP_DELETE  = 2'd2,
    OP_REPLACE = 2'd3
  } op_e;

  // One list slot, 97 bits
  typedef struct packed {
    logic  vld;
    key_t  key;
    size_t size;
  } entry_t;

  // Whole list as stored in one table word
  typedef entry_t [`SL_ENTRIES-1:0] list_state_t;

  // Update command
  typedef struct packed {
    id_t   id;
    op_e   op;
    key_t  key;
    size_t size;
  } upt_req_t;

  // Query command
  typedef struct packed {
    id_t    id;
    level_t level;
  } qry_req_t;

  // Query answer, key and size zero on error
  typedef struct packed {
    key_t      key;
    size_t     size;
    logic      error;
    listsize_t listsize;
  } qry_resp_t;

endpackage

`default_nettype wire

//--- rtl/list_table.sv
/*
  List state memory, one word per ID, registered read.
  Contents are not reset. A write and a read to the same address on one edge
  return the old word.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sorted_lists_params.svh"

module list_table import sorted_lists_pkg::*; (
  input  wire              clk,
  // Read port
  input  wire              rd_en,
  input  wire id_t         rd_addr,
  output list_state_t      rd_state,
  // Write port
  input  wire              wr_en,
  input  wire id_t         wr_addr,
  input  wire list_state_t wr_state
);

  // Storage array
  list_state_t mem [`SL_LISTS];

  // Write side
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_state;
    end
  end

  // Read side, output holds between reads
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_state <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- update/update_pipe.sv
/*
  Read-modify-write pipeline for list updates, one update per cycle.
  No forwarding between stages: updates to one ID need UPT_SPACING cycles.
  ADD does not look for duplicate keys.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sorted_lists_params.svh"

module update_pipe import sorted_lists_pkg::*; (
  input  wire              clk,
  input  wire              rst,
  // Update request
  input  wire              upt_vld,
  input  wire upt_req_t    upt,
  // Table read
  output logic             rd_en,
  output id_t              rd_addr,
  input  wire list_state_t rd_state,
  // Table write, goes to both copies
  output logic             wr_en,
  output id_t              wr_addr,
  output list_state_t      wr_state,
  // Failure report
  output logic             upt_error_vld,
  output id_t              upt_error_id
);

  localparam int N     = `SL_ENTRIES;
  localparam int IDX_W = $clog2(N);

  // Stage valids, bit k belongs to stage k
  logic [3:0] vld_q;
  logic [3:0] vld_d;

  // Stage payloads
  upt_req_t    s0_req;
  upt_req_t    s1_req;
  upt_req_t    s2_req;
  list_state_t s2_state;
  id_t         s3_id;
  list_state_t s3_state;
  logic        s3_err;

  // Execute stage results
  logic [N-1:0]     vld_vec;
  logic [N-1:0]     hit_vec;
  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] hit_idx;
  list_state_t      nxt_state;
  logic             nxt_err;

  assign vld_d = {vld_q[2:0], upt_vld};

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= vld_d;
    end
  end

  // Payload registers load only behind a valid
  always_ff @(posedge clk) begin
    if (vld_d[0]) begin
      s0_req <= upt;
    end
    if (vld_d[1]) begin
      s1_req <= s0_req;
    end
    // Table word arrives one cycle after the read in stage 0
    if (vld_d[2]) begin
      s2_req   <= s1_req;
      s2_state <= rd_state;
    end
    if (vld_d[3]) begin
      s3_id    <= s2_req.id;
      s3_state <= nxt_state;
      s3_err   <= nxt_err;
    end
  end

  // Read issued from stage 0
  assign rd_en   = vld_q[0];
  assign rd_addr = s0_req.id;

  // Slot scan, lowest index wins for both searches
  always_comb begin
    vld_vec  = '0;
    hit_vec  = '0;
    free_idx = '0;
    hit_idx  = '0;
    for (int i = N - 1; i >= 0; i--) begin
      vld_vec[i] = s2_state[i].vld;
      hit_vec[i] = s2_state[i].vld && (s2_state[i].key == s2_req.key);
      if (!s2_state[i].vld) begin
        free_idx = IDX_W'(i);
      end
      if (hit_vec[i]) begin
        hit_idx = IDX_W'(i);
      end
    end
  end

  // Apply the opcode
  // A failing op leaves the word as it was read
  always_comb begin
    nxt_state = s2_state;
    nxt_err   = 1'b0;
    case (s2_req.op)
      OP_CLEAR: begin
        nxt_state = '0;
      end
      OP_ADD: begin
        if (&vld_vec) begin
          nxt_err = 1'b1;
        end else begin
          nxt_state[free_idx] = '{vld: 1'b1, key: s2_req.key, size: s2_req.size};
        end
      end
      OP_DELETE: begin
        if (hit_vec == '0) begin
          nxt_err = 1'b1;
        end else begin
          nxt_state[hit_idx].vld = 1'b0;
        end
      end
      OP_REPLACE: begin
        if (hit_vec == '0) begin
          nxt_err = 1'b1;
        end else begin
          nxt_state[hit_idx].size = s2_req.size;
        end
      end
      default: begin
        nxt_state = s2_state;
      end
    endcase
  end

  // Stage 3 writes back on the next edge
  assign wr_en    = vld_q[3];
  assign wr_addr  = s3_id;
  assign wr_state = s3_state;

  // Error strobe lands with the write
  always_ff @(posedge clk) begin
    if (rst) begin
      upt_error_vld <= 1'b0;
    end else begin
      upt_error_vld <= vld_q[3] && s3_err;
    end
  end

  always_ff @(posedge clk) begin
    if (vld_q[3] && s3_err) begin
      upt_error_id <= s3_id;
    end
  end

  // Every error strobe traces back to an update taken UPT_LATENCY cycles before
  a_err_from_stage3: assert property (@(posedge clk) disable iff (rst)
    upt_error_vld |-> $past(upt_vld, `UPT_LATENCY) &&
                      (upt_error_id == $past(upt.id, `UPT_LATENCY)));

  // Opcode must be known once it reaches execute
  a_op_known: assert property (@(posedge clk) disable iff (rst)
    vld_q[2] |-> !$isunknown(s2_req.op));

endmodule

`default_nettype wire

//--- query/sort_network.sv
/*
  Odd-even transposition sorter, one registered layer per entry.
  Valid entries first in ascending key order, invalid entries last.
  Output trails input by SL_ENTRIES cycles; layers load only behind a valid.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sorted_lists_params.svh"

module sort_network import sorted_lists_pkg::*; (
  input  wire              clk,
  input  wire              rst,
  input  wire              in_vld,
  input  wire list_state_t in_state,
  output list_state_t      out_state
);

  localparam int N = `SL_ENTRIES;

  // Layer valids, last layer has no successor so no flop
  logic [N-2:0] vld_q;
  logic [N-1:0] vld_d;

  list_state_t stage_d [N];
  list_state_t stage_q [N];

  // True when lower slot a must trade places with upper slot b
  function automatic logic must_swap(entry_t a, entry_t b);
    logic r;
    r = (!a.vld && b.vld) || (a.vld && b.vld && (a.key > b.key));
    return r;
  endfunction

  // One compare-exchange layer
  // Phase 0 pairs (0,1),(2,3).. phase 1 pairs (1,2),(3,4)..
  function automatic list_state_t cx_layer(list_state_t s, int phase);
    list_state_t r;
    r = s;
    for (int i = 0; i < N - 1; i++) begin
      if (((i % 2) == phase) && must_swap(s[i], s[i+1])) begin
        r[i]   = s[i+1];
        r[i+1] = s[i];
      end
    end
    return r;
  endfunction

  assign vld_d = {vld_q, in_vld};

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= vld_d[N-2:0];
    end
  end

  // Layer inputs, phase alternates per layer
  always_comb begin
    stage_d[0] = cx_layer(in_state, 0);
    for (int l = 1; l < N; l++) begin
      stage_d[l] = cx_layer(stage_q[l-1], l % 2);
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < N; l++) begin
      if (vld_d[l]) begin
        stage_q[l] <= stage_d[l];
      end
    end
  end

  // N layers are enough to fully sort N slots
  assign out_state = stage_q[N-1];

endmodule

`default_nettype wire

//--- query/query_pipe.sv
/*
  Query pipeline: read list, sort, pick the entry at the level, count valids.
  One query per cycle, response after QRY_LATENCY cycles.
  Out of range level or empty slot gives error with zero key and size.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sorted_lists_params.svh"

module query_pipe import sorted_lists_pkg::*; (
  input  wire              clk,
  input  wire              rst,
  // Query request
  input  wire              qry_vld,
  input  wire qry_req_t    qry,
  // Table read
  output logic             rd_en,
  output id_t              rd_addr,
  input  wire list_state_t rd_state,
  // Response
  output logic             qry_resp_vld,
  output qry_resp_t        qry_resp
);

  localparam int N     = `SL_ENTRIES;
  // Request, read, state capture, then one position per sorter layer
  localparam int DEPTH = N + 3;

  logic [DEPTH-1:0] vld_q;
  logic [DEPTH-1:0] vld_d;

  id_t         q0_id;
  level_t      lvl_q [DEPTH];
  list_state_t q2_state;
  list_state_t sorted;

  // Output selection
  entry_t    sel;
  listsize_t cnt;
  qry_resp_t resp_d;

  assign vld_d = {vld_q[DEPTH-2:0], qry_vld};

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= vld_d;
    end
  end

  // Level rides a delay line beside the read and the sorter
  always_ff @(posedge clk) begin
    if (vld_d[0]) begin
      q0_id    <= qry.id;
      lvl_q[0] <= qry.level;
    end
    for (int i = 1; i < DEPTH; i++) begin
      if (vld_d[i]) begin
        lvl_q[i] <= lvl_q[i-1];
      end
    end
    if (vld_d[2]) begin
      q2_state <= rd_state;
    end
  end

  assign rd_en   = vld_q[0];
  assign rd_addr = q0_id;

  sort_network u_sort (
    .clk       (clk),
    .rst       (rst),
    .in_vld    (vld_q[2]),
    .in_state  (q2_state),
    .out_state (sorted)
  );

  // Pick and count at the sorter output
  always_comb begin
    sel = '0;
    cnt = '0;
    for (int i = 0; i < N; i++) begin
      if (lvl_q[DEPTH-1] == level_t'(i)) begin
        sel = sorted[i];
      end
      cnt = cnt + listsize_t'(sorted[i].vld);
    end
    resp_d.error    = !sel.vld || (lvl_q[DEPTH-1] >= level_t'(N));
    resp_d.key      = resp_d.error ? '0 : sel.key;
    resp_d.size     = resp_d.error ? '0 : sel.size;
    resp_d.listsize = cnt;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      qry_resp_vld <= 1'b0;
    end else begin
      qry_resp_vld <= vld_q[DEPTH-1];
    end
  end

  always_ff @(posedge clk) begin
    if (vld_q[DEPTH-1]) begin
      qry_resp <= resp_d;
    end
  end

  // Fixed latency, no query is lost or delayed
  a_qry_latency: assert property (@(posedge clk) disable iff (rst)
    qry_vld |-> ##(`QRY_LATENCY) qry_resp_vld);

endmodule

`default_nettype wire

//--- rtl/sorted_lists.sv
/*
  Sorted list engine: update and query pipelines over two table copies.
  Table is not reset, so CLEAR each ID before first use.
  Updates to one ID must be UPT_SPACING cycles apart; no handshake.
*/
`timescale 1ns/1ps
`default_nettype none

module sorted_lists import sorted_lists_pkg::*; (
  input  wire           clk,
  input  wire           rst,
  // Update
  input  wire           upt_vld,
  input  wire upt_req_t upt,
  output logic          upt_error_vld,
  output id_t           upt_error_id,
  // Query
  input  wire           qry_vld,
  input  wire qry_req_t qry,
  output logic          qry_resp_vld,
  output qry_resp_t     qry_resp
);

  // Update side table port
  logic        upt_rd_en;
  id_t         upt_rd_addr;
  list_state_t upt_rd_state;

  // Shared write, same word into both copies
  logic        wr_en;
  id_t         wr_addr;
  list_state_t wr_state;

  // Query side table port
  logic        qry_rd_en;
  id_t         qry_rd_addr;
  list_state_t qry_rd_state;

  update_pipe u_upt_pipe (
    .clk           (clk),
    .rst           (rst),
    .upt_vld       (upt_vld),
    .upt           (upt),
    .rd_en         (upt_rd_en),
    .rd_addr       (upt_rd_addr),
    .rd_state      (upt_rd_state),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_state      (wr_state),
    .upt_error_vld (upt_error_vld),
    .upt_error_id  (upt_error_id)
  );

  // Copy read by the update pipeline
  list_table u_upt_table (
    .clk      (clk),
    .rd_en    (upt_rd_en),
    .rd_addr  (upt_rd_addr),
    .rd_state (upt_rd_state),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_state (wr_state)
  );

  // Copy read by the query pipeline
  list_table u_qry_table (
    .clk      (clk),
    .rd_en    (qry_rd_en),
    .rd_addr  (qry_rd_addr),
    .rd_state (qry_rd_state),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_state (wr_state)
  );

  query_pipe u_qry_pipe (
    .clk          (clk),
    .rst          (rst),
    .qry_vld      (qry_vld),
    .qry          (qry),
    .rd_en        (qry_rd_en),
    .rd_addr      (qry_rd_addr),
    .rd_state     (qry_rd_state),
    .qry_resp_vld (qry_resp_vld),
    .qry_resp     (qry_resp)
  );

endmodule

`default_nettype wire

//--- tests/tb_sorted_lists.sv
/*
  Testbench for sorted_lists, commands and expected results from a text file.
  Run from the project root so the stimulus path resolves.
  Stops at the first mismatch.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sorted_lists_params.svh"

module tb_sorted_lists import sorted_lists_pkg::*; ();

  // Longest wait for any strobe
  localparam int WAIT_LIMIT = 4 * `QRY_LATENCY;

  logic      clk;
  logic      rst;
  logic      upt_vld;
  upt_req_t  upt;
  logic      upt_error_vld;
  id_t       upt_error_id;
  logic      qry_vld;
  qry_req_t  qry;
  logic      qry_resp_vld;
  qry_resp_t qry_resp;

  // Expected results in issue order
  id_t       exp_err_q[$];
  qry_resp_t exp_resp_q[$];

  sorted_lists DUT (
    .clk           (clk),
    .rst           (rst),
    .upt_vld       (upt_vld),
    .upt           (upt),
    .upt_error_vld (upt_error_vld),
    .upt_error_id  (upt_error_id),
    .qry_vld       (qry_vld),
    .qry           (qry),
    .qry_resp_vld  (qry_resp_vld),
    .qry_resp      (qry_resp)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_upt_error(id_t got, id_t exp);
    if (got !== exp) begin
      $display("FAIL upt_error_id got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  // Field by field so the line names what differs
  task automatic check_qry_resp(qry_resp_t got, qry_resp_t exp);
    if (got.key !== exp.key) begin
      $display("FAIL qry_resp.key got %h expected %h", got.key, exp.key);
      abort_run();
    end else if (got.size !== exp.size) begin
      $display("FAIL qry_resp.size got %h expected %h", got.size, exp.size);
      abort_run();
    end else if (got.error !== exp.error) begin
      $display("FAIL qry_resp.error got %h expected %h", got.error, exp.error);
      abort_run();
    end else if (got.listsize !== exp.listsize) begin
      $display("FAIL qry_resp.listsize got %h expected %h", got.listsize, exp.listsize);
      abort_run();
    end
  endtask

  // Inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drain_errors();
    int n;
    n = 0;
    while (exp_err_q.size() != 0) begin
      if (n == WAIT_LIMIT) begin
        $display("Timeout, upt_error_vld never arrived for ID %h", exp_err_q[0]);
        abort_run();
      end
      next_cycle();
      n++;
    end
  endtask

  // One update, then the spacing the table needs before the same ID again
  task automatic drive_update(id_t id, op_e op, key_t key, size_t size, logic exp_err);
    upt_vld = 1'b1;
    upt     = '{id: id, op: op, key: key, size: size};
    if (exp_err) begin
      exp_err_q.push_back(id);
    end
    next_cycle();
    upt_vld = 1'b0;
    repeat (`UPT_SPACING) next_cycle();
    drain_errors();
  endtask

  task automatic drive_query(id_t id, level_t level, qry_resp_t exp);
    qry_vld = 1'b1;
    qry     = '{id: id, level: level};
    exp_resp_q.push_back(exp);
    next_cycle();
    qry_vld = 1'b0;
  endtask

  // Strobes are sampled mid cycle, away from the edge
  always @(negedge clk) begin
    if (!rst && upt_error_vld === 1'b1) begin
      if (exp_err_q.size() == 0) begin
        $display("Unexpected upt_error_vld for ID %h", upt_error_id);
        abort_run();
      end else begin
        check_upt_error(upt_error_id, exp_err_q.pop_front());
      end
    end
    if (!rst && qry_resp_vld === 1'b1) begin
      if (exp_resp_q.size() == 0) begin
        $display("Unexpected qry_resp_vld with no query outstanding");
        abort_run();
      end else begin
        check_qry_resp(qry_resp, exp_resp_q.pop_front());
      end
    end
  end

  initial begin
    int                fd;
    int                n;
    logic [8*256-1:0]  line;
    logic [7:0]        cmd;
    logic [31:0]       f_id;
    logic [31:0]       f_arg;
    key_t              f_key;
    size_t             f_size;
    logic [31:0]       f_err;
    logic [31:0]       f_ls;
    qry_resp_t         exp;
    rst     = 1'b1;
    upt_vld = 1'b0;
    qry_vld = 1'b0;
    upt     = '0;
    qry     = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    fd = $fopen("tests/sorted_lists_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      abort_run();
    end
    line = '0;
    while ($fgets(line, fd) != 0) begin
      // Blank lines give no command character
      if ($sscanf(line, " %c", cmd) == 1) begin
        case (cmd)
          "U": begin
            n = $sscanf(line, "U %h %h %h %h %h", f_id, f_arg, f_key, f_size, f_err);
            if (n != 5) begin
              $display("Malformed update line in the stimulus file");
              abort_run();
            end
            drive_update(id_t'(f_id), op_e'(f_arg[1:0]), f_key, f_size, f_err[0]);
          end
          "Q": begin
            n = $sscanf(line, "Q %h %h %h %h %h %h", f_id, f_arg, f_key, f_size,
                        f_err, f_ls);
            if (n != 6) begin
              $display("Malformed query line in the stimulus file");
              abort_run();
            end
            exp = '{key: f_key, size: f_size, error: f_err[0],
                    listsize: listsize_t'(f_ls)};
            drive_query(id_t'(f_id), level_t'(f_arg), exp);
          end
          "I": begin
            n = $sscanf(line, "I %d", f_arg);
            if (n != 1) begin
              $display("Malformed idle line in the stimulus file");
              abort_run();
            end
            repeat (f_arg) next_cycle();
          end
          "#": begin
            // Comment line
          end
          default: begin
            $display("Unknown command in the stimulus file");
            abort_run();
          end
        endcase
      end
      line = '0;
    end
    $fclose(fd);
    // Wait for the strobes still in flight
    n = 0;
    while ((exp_err_q.size() != 0 || exp_resp_q.size() != 0) && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    // A few more cycles to catch stray strobes
    repeat (4) next_cycle();
    if (exp_err_q.size() != 0 || exp_resp_q.size() != 0) begin
      $display("Timeout, %0d error strobes and %0d responses never arrived",
               exp_err_q.size(), exp_resp_q.size());
      $display("TEST FAILED");
      $fatal(1, "Stopped with results outstanding");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+common
common/sorted_lists_pkg.sv
rtl/list_table.sv
update/update_pipe.sv
query/sort_network.sv
query/query_pipe.sv
rtl/sorted_lists.sv
tests/tb_sorted_lists.sv

//--- tests/sorted_lists_stimulus.txt
# U id op key size err   op: 0 clear, 1 add, 2 delete, 3 replace
# Q id level key size err listsize   I idle_cycles (decimal), all other fields hex
U 01 0 0000000000000000 00000000 0
U 02 0 0000000000000000 00000000 0
U 03 0 0000000000000000 00000000 0
# Freshly cleared list
Q 01 00 0000000000000000 00000000 1 00
# Unordered adds come back sorted
U 01 1 0000000000000030 00000003 0
U 01 1 0000000000000010 00000001 0
U 01 1 0000000000000020 00000002 0
Q 01 00 0000000000000010 00000001 0 03
Q 01 01 0000000000000020 00000002 0 03
Q 01 02 0000000000000030 00000003 0 03
Q 01 03 0000000000000000 00000000 1 03
Q 01 05 0000000000000000 00000000 1 03
U 01 1 0000000000000040 00000004 0
Q 01 03 0000000000000040 00000004 0 04
# Add into a full list fails and leaves it as it was
U 01 1 0000000000000050 00000005 1
Q 01 00 0000000000000010 00000001 0 04
Q 01 01 0000000000000020 00000002 0 04
Q 01 02 0000000000000030 00000003 0 04
Q 01 03 0000000000000040 00000004 0 04
Q 01 04 0000000000000000 00000000 1 04
# Delete, then absent key delete and replace
U 01 2 0000000000000020 00000000 0
Q 01 00 0000000000000010 00000001 0 03
Q 01 01 0000000000000030 00000003 0 03
Q 01 02 0000000000000040 00000004 0 03
U 01 2 0000000000000020 00000000 1
U 01 3 0000000000000099 00000077 1
U 03 2 0000000000000001 00000000 1
Q 01 01 0000000000000030 00000003 0 03
Q 03 00 0000000000000000 00000000 1 00
# Replace touches only the size
U 01 3 0000000000000030 00000abc 0
Q 01 00 0000000000000010 00000001 0 03
Q 01 01 0000000000000030 00000abc 0 03
Q 01 02 0000000000000040 00000004 0 03
U 01 1 0000000000000005 00000005 0
U 02 1 8000000000000000 deadbeef 0
U 02 1 0000000000000007 00000007 0
I 4
# Back-to-back queries over several IDs
Q 02 00 0000000000000007 00000007 0 02
Q 01 02 0000000000000030 00000abc 0 04
Q 02 01 8000000000000000 deadbeef 0 02
Q 03 00 0000000000000000 00000000 1 00
Q 01 00 0000000000000005 00000005 0 04
Q 02 02 0000000000000000 00000000 1 02
Q 01 ff 0000000000000000 00000000 1 04
Q 01 03 0000000000000040 00000004 0 04
